/* common/cpu_common_pkg.sv */
package cpu_common_pkg;

    // Basic data widths
    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;
    typedef logic [4:0]  regaddr_t;

    // Major opcodes used by the expanded RV32I forms
    localparam logic [6:0] OP        = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Load, store and branch funct3
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // addi x0, x0, 0
    localparam word_t NOP_IR = 32'h0000_0013;

    // One fetched word, seen whole or as two halfwords
    // Halfword 0 is the lower one and comes first in program order
    typedef union packed {
        word_t       word;
        half_t [1:0] half;
    } fetch_word_u;

endpackage

/* common/instr_if.sv */
`timescale 1ns/10ps

// Raw instruction from the aligner towards the decompressor
interface instr_if;
    import cpu_common_pkg::*;

    logic  valid;
    // Upper halfword is zero for a compressed instruction
    word_t raw;
    word_t pc;
    logic  ready;

    modport src (
        output valid,
        output raw,
        output pc,
        input  ready
    );

    modport dst (
        input  valid,
        input  raw,
        input  pc,
        output ready
    );

endinterface

/* source/fetch_ctrl.sv */
`timescale 1ns/10ps

module fetch_ctrl (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic redirect_i,
    input  logic space_i,
    input  logic mem_req_ready_i,
    input  logic mem_rsp_valid_i,
    output logic mem_req_valid_o,
    output logic step_o,
    output logic rsp_take_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_RSP,
        DRAIN
    } state_t;

    state_t state_q;
    state_t state_d;
    // Low until the first clock edge after reset release
    logic   run_q;

    // No request in the redirect cycle, the counter loads the new target first
    assign mem_req_valid_o = run_q && (state_q == IDLE) && space_i && !redirect_i;
    assign step_o          = mem_req_valid_o && mem_req_ready_i;

    // A response that meets a redirect belongs to the old stream
    assign rsp_take_o = (state_q == WAIT_RSP) && mem_rsp_valid_i && !redirect_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (step_o) begin
                    state_d = WAIT_RSP;
                end
            end
            WAIT_RSP: begin
                if (mem_rsp_valid_i) begin
                    state_d = IDLE;
                end else if (redirect_i) begin
                    state_d = DRAIN;
                end
            end
            // Stale word still in flight, wait for it and drop it
            DRAIN: begin
                if (mem_rsp_valid_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            run_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            run_q   <= 1'b1;
        end
    end

endmodule

/* source/fetch_pc_counter.sv */
`timescale 1ns/10ps

module fetch_pc_counter #(
    parameter cpu_common_pkg::word_t RESET_PC = 32'h0000_1000
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  redirect_i,
    input  logic                  step_i,
    input  cpu_common_pkg::word_t redirect_pc_i,
    output cpu_common_pkg::word_t fetch_addr_o
);
    import cpu_common_pkg::*;

    word_t addr_q;

    assign fetch_addr_o = addr_q;

    // Always a word address, the aligner handles the halfword offset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_q <= {RESET_PC[31:2], 2'b00};
        end else if (redirect_i) begin
            addr_q <= {redirect_pc_i[31:2], 2'b00};
        end else if (step_i) begin
            addr_q <= addr_q + 32'd4;
        end
    end

endmodule

/* decompress/instr_aligner.sv */
`timescale 1ns/10ps

module instr_aligner #(
    parameter cpu_common_pkg::word_t RESET_PC = 32'h0000_1000
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  redirect_i,
    input  logic                  rsp_take_i,
    input  cpu_common_pkg::word_t redirect_pc_i,
    input  cpu_common_pkg::word_t rsp_data_i,
    output logic                  space_o,
    instr_if.src                  out
);
    import cpu_common_pkg::*;

    half_t       hw_q [3];
    half_t       hw_d [3];
    logic [1:0]  count_q;
    logic [1:0]  count_d;
    logic [1:0]  level;
    logic        skip_q;
    word_t       pc_q;
    logic        is_comp;
    logic        pop;
    half_t       first_hw;
    fetch_word_u rsp_word;
    fetch_word_u out_word;

    assign rsp_word = rsp_data_i;

    // Slot 0 is the oldest halfword
    assign is_comp = hw_q[0][1:0] != 2'b11;
    assign space_o = count_q < 2'd2;

    assign out.valid = ((count_q != 2'd0) && is_comp) || (count_q >= 2'd2);
    assign out.pc    = pc_q;
    assign pop       = out.valid && out.ready;

    always_comb begin
        out_word.half[0] = hw_q[0];
        out_word.half[1] = is_comp ? 16'h0000 : hw_q[1];
        out.raw          = out_word.word;
    end

    // Entry of a redirect to an odd halfword drops the lower half once
    assign first_hw = skip_q ? rsp_word.half[1] : rsp_word.half[0];

    always_comb begin
        hw_d  = hw_q;
        level = count_q;
        if (pop) begin
            if (is_comp) begin
                hw_d[0] = hw_q[1];
                hw_d[1] = hw_q[2];
                level   = count_q - 2'd1;
            end else begin
                hw_d[0] = hw_q[2];
                level   = count_q - 2'd2;
            end
        end
        if (rsp_take_i) begin
            for (int i = 0; i < 3; i++) begin
                if (2'(i) == level) begin
                    hw_d[i] = first_hw;
                end else if (!skip_q && (2'(i) == level + 2'd1)) begin
                    hw_d[i] = rsp_word.half[1];
                end
            end
            level = level + (skip_q ? 2'd1 : 2'd2);
        end
        count_d = redirect_i ? 2'd0 : level;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= 2'd0;
            skip_q  <= RESET_PC[1];
            pc_q    <= RESET_PC;
        end else begin
            count_q <= count_d;
            if (redirect_i) begin
                skip_q <= redirect_pc_i[1];
                pc_q   <= {redirect_pc_i[31:1], 1'b0};
            end else begin
                if (rsp_take_i) begin
                    skip_q <= 1'b0;
                end
                if (pop) begin
                    pc_q <= pc_q + (is_comp ? 32'd2 : 32'd4);
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        hw_q <= hw_d;
    end

endmodule

/* decompress/cpu_decompress.sv */
`timescale 1ns/10ps

module cpu_decompress (
    instr_if.dst                  in,
    input  logic                  instr_ready_i,
    output logic                  instr_valid_o,
    output logic                  compressed_o,
    output cpu_common_pkg::word_t ir_o,
    output cpu_common_pkg::word_t pc_o
);
    import cpu_common_pkg::*;

    word_t       ir;
    regaddr_t    rs1;
    regaddr_t    rs2;
    regaddr_t    rs1s;
    regaddr_t    rs2s;
    logic [11:0] imm_ciw;
    logic [11:0] imm_cl;
    logic [19:0] imm_ci;
    logic [20:1] imm_cj;
    logic [12:1] imm_cb;
    logic [11:0] imm_lwsp;
    logic [11:0] imm_swsp;
    logic [11:0] imm_16sp;
    logic [19:0] jal_imm;
    logic [4:0]  shamt;

    // Handshake and PC go straight through
    assign in.ready      = instr_ready_i;
    assign instr_valid_o = in.valid;
    assign pc_o          = in.pc;

    assign ir = in.raw;
    assign compressed_o = ir[1:0] != 2'b11;

    // Field and immediate unpacking
    always_comb begin
        rs1      = ir[11:7];
        rs2      = ir[6:2];
        rs1s     = {2'b01, ir[9:7]};
        rs2s     = {2'b01, ir[4:2]};
        imm_ciw  = {2'b00, ir[10:7], ir[12:11], ir[5], ir[6], 2'b00};
        imm_cl   = {5'b00000, ir[5], ir[12:10], ir[6], 2'b00};
        imm_ci   = {{15{ir[12]}}, ir[6:2]};
        imm_cj   = {{10{ir[12]}}, ir[8], ir[10:9], ir[6], ir[7], ir[2], ir[11], ir[5:3]};
        imm_cb   = {{5{ir[12]}}, ir[6:5], ir[2], ir[11:10], ir[4:3]};
        imm_lwsp = {4'b0000, ir[3:2], ir[12], ir[6:4], 2'b00};
        imm_swsp = {4'b0000, ir[8:7], ir[12:9], 2'b00};
        imm_16sp = {{3{ir[12]}}, ir[4:3], ir[5], ir[2], ir[6], 4'b0000};
        // Reordered into the jal immediate layout
        jal_imm  = {imm_cj[20], imm_cj[10:1], imm_cj[11], imm_cj[19:12]};
        shamt    = imm_ci[4:0];
    end

    // First matching pattern wins, reserved and hint forms sit above the real ones
    always_comb begin
        priority casez (ir[15:0])
            // Quadrant 0
            // C.ADDI4SPN with zero immediate, includes the all-zero halfword
            16'b00000000000???00: ir_o = NOP_IR;
            16'b000???????????00: ir_o = {imm_ciw, 5'd2, F3_ADD_SUB, rs2s, OP_IMM};
            // C.LW
            16'b010???????????00: ir_o = {imm_cl, rs1s, F3_LW, rs2s, OP_LOAD};
            // C.SW
            16'b110???????????00: ir_o = {imm_cl[11:5], rs2s, rs1s, F3_SW, imm_cl[4:0], OP_STORE};

            // Quadrant 1
            // C.NOP and the C.ADDI hints
            16'b000?00000?????01: ir_o = NOP_IR;
            16'b0000?????0000001: ir_o = NOP_IR;
            16'b000???????????01: ir_o = {imm_ci[11:0], rs1, F3_ADD_SUB, rs1, OP_IMM};
            // C.JAL
            16'b001???????????01: ir_o = {jal_imm, 5'd1, OP_JAL};
            // C.LI
            16'b010?00000?????01: ir_o = NOP_IR;
            16'b010???????????01: ir_o = {imm_ci[11:0], 5'd0, F3_ADD_SUB, rs1, OP_IMM};
            // C.ADDI16SP, zero immediate is reserved
            16'b0110?????0000001: ir_o = NOP_IR;
            16'b011?00010?????01: ir_o = {imm_16sp, 5'd2, F3_ADD_SUB, 5'd2, OP_IMM};
            // C.LUI
            16'b011?000?0?????01: ir_o = NOP_IR;
            16'b011???????????01: ir_o = {imm_ci, rs1, OP_LUI};
            // Shift amounts of 32 and up do not exist on RV32
            16'b10010?????????01: ir_o = NOP_IR;
            // C.SRLI
            16'b100000???0000001: ir_o = NOP_IR;
            16'b100000????????01: ir_o = {7'b0000000, shamt, rs1s, F3_SRL_SRA, rs1s, OP_IMM};
            // C.SRAI
            16'b100001???0000001: ir_o = NOP_IR;
            16'b100001????????01: ir_o = {7'b0100000, shamt, rs1s, F3_SRL_SRA, rs1s, OP_IMM};
            // C.ANDI
            16'b100?10????????01: ir_o = {imm_ci[11:0], rs1s, F3_AND, rs1s, OP_IMM};
            // C.SUB, C.XOR, C.OR, C.AND
            16'b100011???00???01: ir_o = {7'b0100000, rs2s, rs1s, F3_ADD_SUB, rs1s, OP};
            16'b100011???01???01: ir_o = {7'b0000000, rs2s, rs1s, F3_XOR, rs1s, OP};
            16'b100011???10???01: ir_o = {7'b0000000, rs2s, rs1s, F3_OR, rs1s, OP};
            16'b100011???11???01: ir_o = {7'b0000000, rs2s, rs1s, F3_AND, rs1s, OP};
            // RV64 only forms
            16'b100111????????01: ir_o = NOP_IR;
            // C.J
            16'b101???????????01: ir_o = {jal_imm, 5'd0, OP_JAL};
            // C.BEQZ and C.BNEZ
            16'b110???????????01: ir_o = {imm_cb[12], imm_cb[10:5], 5'd0, rs1s, F3_BEQ,
                                          imm_cb[4:1], imm_cb[11], OP_BRANCH};
            16'b111???????????01: ir_o = {imm_cb[12], imm_cb[10:5], 5'd0, rs1s, F3_BNE,
                                          imm_cb[4:1], imm_cb[11], OP_BRANCH};

            // Quadrant 2
            // C.SLLI
            16'b0001??????????10: ir_o = NOP_IR;
            16'b0000?????0000010: ir_o = NOP_IR;
            16'b000?00000?????10: ir_o = NOP_IR;
            16'b000???????????10: ir_o = {7'b0000000, shamt, rs1, F3_SLL, rs1, OP_IMM};
            // C.LWSP, rd of x0 is reserved
            16'b010?00000?????10: ir_o = NOP_IR;
            16'b010???????????10: ir_o = {imm_lwsp, 5'd2, F3_LW, rs1, OP_LOAD};
            // C.JR then C.MV
            16'b1000000000000010: ir_o = NOP_IR;
            16'b1000?????0000010: ir_o = {12'h000, rs1, 3'b000, 5'd0, OP_JALR};
            16'b100000000?????10: ir_o = NOP_IR;
            16'b1000??????????10: ir_o = {7'b0000000, rs2, 5'd0, F3_ADD_SUB, rs1, OP};
            // C.EBREAK, C.JALR then C.ADD
            16'b1001000000000010: ir_o = {12'h001, 5'd0, 3'b000, 5'd0, OP_SYSTEM};
            16'b1001?????0000010: ir_o = {12'h000, rs1, 3'b000, 5'd1, OP_JALR};
            16'b100100000?????10: ir_o = NOP_IR;
            16'b1001??????????10: ir_o = {7'b0000000, rs2, rs1, F3_ADD_SUB, rs1, OP};
            // C.SWSP
            16'b110???????????10: ir_o = {imm_swsp[11:5], rs2, 5'd2, F3_SW, imm_swsp[4:0],
                                          OP_STORE};

            // Float forms of the C extension are not supported
            default: ir_o = compressed_o ? NOP_IR : ir;
        endcase
    end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit #(
    parameter cpu_common_pkg::word_t RESET_PC = 32'h0000_1000
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    output logic                  mem_req_valid_o,
    output cpu_common_pkg::word_t mem_addr_o,
    input  logic                  mem_req_ready_i,
    input  logic                  mem_rsp_valid_i,
    input  cpu_common_pkg::word_t mem_rsp_data_i,
    output logic                  instr_valid_o,
    output cpu_common_pkg::word_t instr_o,
    output cpu_common_pkg::word_t pc_o,
    output logic                  compressed_o,
    input  logic                  instr_ready_i,
    input  logic                  redirect_i,
    input  cpu_common_pkg::word_t redirect_pc_i
);

    logic space;
    logic step;
    logic rsp_take;

    instr_if u_instr_if ();

    fetch_ctrl u_fetch_ctrl (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .redirect_i      (redirect_i),
        .space_i         (space),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_req_valid_o (mem_req_valid_o),
        .step_o          (step),
        .rsp_take_o      (rsp_take)
    );

    fetch_pc_counter #(
        .RESET_PC (RESET_PC)
    ) u_fetch_pc_counter (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .redirect_i    (redirect_i),
        .step_i        (step),
        .redirect_pc_i (redirect_pc_i),
        .fetch_addr_o  (mem_addr_o)
    );

    instr_aligner #(
        .RESET_PC (RESET_PC)
    ) u_instr_aligner (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .redirect_i    (redirect_i),
        .rsp_take_i    (rsp_take),
        .redirect_pc_i (redirect_pc_i),
        .rsp_data_i    (mem_rsp_data_i),
        .space_o       (space),
        .out           (u_instr_if.src)
    );

    cpu_decompress u_cpu_decompress (
        .in            (u_instr_if.dst),
        .instr_ready_i (instr_ready_i),
        .instr_valid_o (instr_valid_o),
        .compressed_o  (compressed_o),
        .ir_o          (instr_o),
        .pc_o          (pc_o)
    );

endmodule

/* dv/fetch_unit_sva.sv */
`timescale 1ns/10ps

module fetch_unit_sva #(
    parameter cpu_common_pkg::word_t RESET_PC = 32'h0000_1000
) (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  mem_req_valid_o,
    input logic                  mem_req_ready_i,
    input cpu_common_pkg::word_t mem_addr_o,
    input logic                  instr_valid_o,
    input logic                  instr_ready_i,
    input cpu_common_pkg::word_t instr_o,
    input cpu_common_pkg::word_t pc_o,
    input logic                  compressed_o,
    input logic                  redirect_i,
    input cpu_common_pkg::word_t redirect_pc_i
);
    import cpu_common_pkg::*;

    logic  fail_seen = 1'b0;
    word_t next_pc;
    logic  accept;

    // Expected expansion per program offset, outside the program the fill word
    function automatic word_t expected_ir(input word_t pc);
        word_t ofs;
        ofs = pc - RESET_PC;
        case (ofs)
            32'h00: expected_ir = 32'h0050_0093;
            32'h04: expected_ir = 32'h0030_8093;
            32'h06: expected_ir = 32'h1234_52B7;
            32'h0A: expected_ir = 32'hFFF0_0113;
            32'h0C: expected_ir = 32'h0045_2483;
            32'h0E: expected_ir = 32'h00B5_2423;
            32'h10: expected_ir = 32'h0020_81B3;
            32'h14: expected_ir = 32'h0024_5413;
            32'h16: expected_ir = 32'h00A4_F4B3;
            32'h18: expected_ir = 32'h0060_02B3;
            32'h1A: expected_ir = 32'h0062_82B3;
            32'h1C: expected_ir = 32'h00C1_2383;
            32'h1E: expected_ir = 32'h0081_2823;
            32'h20: expected_ir = NOP_IR;
            32'h22: expected_ir = 32'h4011_8233;
            32'h26: expected_ir = 32'h0004_0463;
            32'h28: expected_ir = 32'h0040_006F;
            32'h2A: expected_ir = 32'h0000_80E7;
            32'h2C: expected_ir = 32'hFF05_0513;
            default: expected_ir = {pc[31:2], 2'b11};
        endcase
    endfunction

    function automatic logic expected_comp(input word_t pc);
        word_t ofs;
        ofs = pc - RESET_PC;
        case (ofs)
            32'h04, 32'h0A, 32'h0C, 32'h0E, 32'h14, 32'h16, 32'h18,
            32'h1A, 32'h1C, 32'h1E, 32'h20, 32'h26, 32'h28, 32'h2A: expected_comp = 1'b1;
            default: expected_comp = 1'b0;
        endcase
    endfunction

    assign accept = instr_valid_o && instr_ready_i;

    // PC that the next accepted instruction must carry
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            next_pc <= RESET_PC;
        end else if (redirect_i) begin
            next_pc <= {redirect_pc_i[31:1], 1'b0};
        end else if (accept) begin
            next_pc <= pc_o + (expected_comp(pc_o) ? 32'd2 : 32'd4);
        end
    end

    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i || $rose(rst_n_i) |-> !mem_req_valid_o && !instr_valid_o)
        else begin
            fail_seen = 1'b1;
            $error("request or instruction valid during reset or right after it");
        end

    a_first_req: assert property (@(posedge clk_i)
        $rose(rst_n_i) |=> mem_req_valid_o && mem_addr_o == RESET_PC)
        else begin
            fail_seen = 1'b1;
            $error("mismatch at %0t: first request missing or not at %h", $time, RESET_PC);
        end

    a_instr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_o |-> instr_o == expected_ir(pc_o))
        else begin
            fail_seen = 1'b1;
            $error("mismatch at %0t: instr %h at pc %h", $time, instr_o, pc_o);
        end

    a_comp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_o |-> compressed_o == expected_comp(pc_o))
        else begin
            fail_seen = 1'b1;
            $error("mismatch at %0t: compressed flag %b at pc %h", $time, compressed_o, pc_o);
        end

    a_next_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |-> pc_o == next_pc)
        else begin
            fail_seen = 1'b1;
            $error("mismatch at %0t: pc %h, expected %h", $time, pc_o, next_pc);
        end

    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_o && !instr_ready_i && !redirect_i |=>
            instr_valid_o && $stable(instr_o) && $stable(pc_o) && $stable(compressed_o))
        else begin
            fail_seen = 1'b1;
            $error("mismatch at %0t: instruction changed during a stall", $time);
        end

    a_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_i |=> !instr_valid_o)
        else begin
            fail_seen = 1'b1;
            $error("instruction still valid in the cycle after a redirect");
        end

    a_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_valid_o && !mem_req_ready_i |=> $stable(mem_addr_o))
        else begin
            fail_seen = 1'b1;
            $error("mismatch at %0t: fetch address moved while waiting", $time);
        end

    a_pc_even: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_o |-> !pc_o[0])
        else begin
            fail_seen = 1'b1;
            $error("mismatch at %0t: odd pc %h", $time, pc_o);
        end

endmodule

bind fetch_unit fetch_unit_sva #(
    .RESET_PC (RESET_PC)
) u_sva (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_addr_o      (mem_addr_o),
    .instr_valid_o   (instr_valid_o),
    .instr_ready_i   (instr_ready_i),
    .instr_o         (instr_o),
    .pc_o            (pc_o),
    .compressed_o    (compressed_o),
    .redirect_i      (redirect_i),
    .redirect_pc_i   (redirect_pc_i)
);

/* dv/fetch_unit_tb.sv */
`timescale 1ns/10ps

module fetch_unit_tb;
    import cpu_common_pkg::*;

    localparam word_t RESET_PC = 32'h0000_1000;
    localparam int    WAIT_LIMIT = 2000;

    logic  clk_i;
    logic  rst_n_i;
    logic  mem_req_valid_o;
    word_t mem_addr_o;
    logic  mem_req_ready_i;
    logic  mem_rsp_valid_i;
    word_t mem_rsp_data_i;
    logic  instr_valid_o;
    word_t instr_o;
    word_t pc_o;
    logic  compressed_o;
    logic  instr_ready_i;
    logic  redirect_i;
    word_t redirect_pc_i;

    word_t prog [12];
    word_t pend_addr;
    int    countdown;
    logic  req_acc;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_addr_o      (mem_addr_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .instr_valid_o   (instr_valid_o),
        .instr_o         (instr_o),
        .pc_o            (pc_o),
        .compressed_o    (compressed_o),
        .instr_ready_i   (instr_ready_i),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Program words, lower halfword first in program order
    initial begin
        prog[0]  = 32'h0050_0093;  // addi x1,x0,5
        prog[1]  = 32'h52B7_008D;  // c.addi, low half of lui
        prog[2]  = 32'h517D_1234;  // high half of lui, c.li
        prog[3]  = 32'hC50C_4144;  // c.lw, c.sw
        prog[4]  = 32'h0020_81B3;  // add x3,x1,x2
        prog[5]  = 32'h8CE9_8009;  // c.srli, c.and
        prog[6]  = 32'h929A_829A;  // c.mv, c.add
        prog[7]  = 32'hC822_43B2;  // c.lwsp, c.swsp
        prog[8]  = 32'h8233_0000;  // reserved halfword, low half of sub
        prog[9]  = 32'hC401_4011;  // high half of sub, c.beqz
        prog[10] = 32'h9082_A011;  // c.j, c.jalr
        prog[11] = 32'hFF05_0513;  // addi x10,x10,-16
    end

    function automatic word_t mem_word(input word_t addr);
        word_t ofs;
        ofs = addr - RESET_PC;
        if (ofs < 32'd48) begin
            mem_word = prog[ofs[5:2]];
        end else begin
            mem_word = {addr[31:2], 2'b11};
        end
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "stopping the run");
    endtask

    // Memory with random latency and random request ready, plus decode stalls
    initial begin
        countdown = 0;
        pend_addr = '0;
        forever begin
            @(negedge clk_i);
            req_acc = rst_n_i && mem_req_valid_o && mem_req_ready_i;
            if (req_acc) begin
                pend_addr = mem_addr_o;
            end
            @(posedge clk_i);
            #1;
            mem_rsp_valid_i = 1'b0;
            if (countdown > 0) begin
                countdown = countdown - 1;
                if (countdown == 0) begin
                    mem_rsp_valid_i = 1'b1;
                    mem_rsp_data_i  = mem_word(pend_addr);
                end
            end
            if (req_acc) begin
                countdown = 1 + int'($urandom % 3);
            end
            mem_req_ready_i = ($urandom % 4) != 0;
            instr_ready_i   = ($urandom % 4) != 0;
        end
    end

    always @(negedge clk_i) begin
        if (uut.u_sva.fail_seen) begin
            abort_run("an assertion in the checker failed");
        end
    end

    task automatic wait_for_pc(input word_t pc);
        logic found;
        found = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !found; i++) begin
            @(negedge clk_i);
            if (instr_valid_o && instr_ready_i && pc_o == pc) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            abort_run($sformatf("timed out waiting for the instruction at pc %h", pc));
        end
    endtask

    // A word still two or more cycles away, so the redirect meets it in flight
    task automatic wait_for_outstanding();
        logic found;
        found = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !found; i++) begin
            @(negedge clk_i);
            if (countdown > 1) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            abort_run("timed out waiting for an outstanding memory request");
        end
    endtask

    task automatic pulse_redirect(input word_t target);
        @(posedge clk_i);
        #1;
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        @(posedge clk_i);
        #1;
        redirect_i    = 1'b0;
    endtask

    initial begin
        rst_n_i         = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        instr_ready_i   = 1'b0;
        redirect_i      = 1'b0;
        redirect_pc_i   = '0;
        void'($urandom(32'h7a54f679));
        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        wait_for_pc(RESET_PC + 32'h2C);
        // Replay from the straddling lui, then from the sub after the reserved half
        wait_for_outstanding();
        pulse_redirect(RESET_PC + 32'h06);
        wait_for_pc(RESET_PC + 32'h2C);
        wait_for_outstanding();
        pulse_redirect(RESET_PC + 32'h22);
        wait_for_pc(RESET_PC + 32'h2C);

        repeat (2) @(posedge clk_i);
        #1;
        if (uut.u_sva.fail_seen) begin
            abort_run("an assertion in the checker failed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* fetch_unit.f */
common/cpu_common_pkg.sv
common/instr_if.sv
source/fetch_ctrl.sv
source/fetch_pc_counter.sv
decompress/instr_aligner.sv
decompress/cpu_decompress.sv
source/fetch_unit.sv
dv/fetch_unit_sva.sv
dv/fetch_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert --top-module fetch_unit_tb \
    -f fetch_unit.f -o fetch_unit_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/fetch_unit_sim +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation returned an error status"
    exit 1
fi

if echo "$output" | grep -q "Everything OK"; then
    exit 0
fi
exit 1
